//--- hw/mem_bus_pkg.sv
package mem_bus_pkg;

    // byte address on both the cache side and the memory side
    typedef logic [31:0] addr_t;

    // one beat on the burst memory bus
    typedef logic [63:0] beat_t;

    // one full cache line
    typedef logic [255:0] line_t;

    localparam int BURST_LEN        = 4;    // beats per line
    localparam int LINE_OFFSET_BITS = 5;    // 32 bytes per line

    // counts beats within one line transfer
    typedef logic [1:0] beat_cnt_t;

endpackage : mem_bus_pkg

//--- hw/arb_pkg.sv
package arb_pkg;

    typedef enum logic [1:0] {
        ARB_IDLE    = 2'b00,
        ARB_SERVE_I = 2'b01,    // instruction port owns the adapter
        ARB_SERVE_D = 2'b10     // data port owns the adapter
    } arb_state_t;

    typedef enum logic [1:0] {
        BURST_IDLE        = 2'b00,
        BURST_READ_WAIT   = 2'b01,
        BURST_WRITE_BEATS = 2'b10,
        BURST_DONE        = 2'b11
    } burst_state_t;

    typedef enum logic {
        OWNER_I = 1'b0,
        OWNER_D = 1'b1
    } owner_t;

endpackage : arb_pkg

//--- hw/line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter
import mem_bus_pkg::*, arb_pkg::*;
#(
    parameter logic D_FIRST = 1'b1      // data port wins a tie when set
)
(
    input   logic       clk,
    input   logic       rst,

    // instruction requester
    input   addr_t      i_addr_i,
    input   logic       i_read_i,
    output  line_t      i_rdata_o,
    output  logic       i_resp_o,

    // data requester
    input   addr_t      d_addr_i,
    input   logic       d_read_i,
    input   logic       d_write_i,
    input   line_t      d_wdata_i,
    output  line_t      d_rdata_o,
    output  logic       d_resp_o,

    // line transfer to the burst adapter
    output  addr_t      xfer_addr_o,
    output  logic       xfer_read_o,
    output  logic       xfer_write_o,
    output  line_t      xfer_wdata_o,
    input   line_t      xfer_rdata_i,
    input   logic       xfer_done_i
);

    arb_state_t state, state_next;
    owner_t     owner, owner_next;

    logic       i_req;
    logic       d_req;
    logic       busy;           // a grant is active
    logic       resp_cycle;     // resp is being driven this cycle
    addr_t      sel_addr;

    assign i_req      = i_read_i;
    assign d_req      = d_read_i | d_write_i;
    assign busy       = (state != ARB_IDLE);
    assign resp_cycle = i_resp_o | d_resp_o;

    always_comb begin
        state_next = state;
        owner_next = owner;
        case (state)
            ARB_IDLE: begin
                // the finished requester still holds its request during resp
                if (!resp_cycle) begin
                    if (d_req && (D_FIRST || !i_req)) begin
                        state_next = ARB_SERVE_D;
                        owner_next = OWNER_D;
                    end else if (i_req) begin
                        state_next = ARB_SERVE_I;
                        owner_next = OWNER_I;
                    end
                end
            end
            ARB_SERVE_I, ARB_SERVE_D: begin
                if (xfer_done_i) begin
                    state_next = ARB_IDLE;
                end
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    // route the owner's command to the adapter
    assign sel_addr     = (owner == OWNER_D) ? d_addr_i : i_addr_i;
    assign xfer_addr_o  = {sel_addr[$bits(addr_t)-1:LINE_OFFSET_BITS],
                           {LINE_OFFSET_BITS{1'b0}}};       // line aligned
    assign xfer_read_o  = busy && ((owner == OWNER_D) ? d_read_i : i_read_i);
    assign xfer_write_o = busy && (owner == OWNER_D) && d_write_i;
    assign xfer_wdata_o = d_wdata_i;                        // only the data port writes

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ARB_IDLE;
            owner    <= OWNER_I;
            i_resp_o <= 1'b0;
            d_resp_o <= 1'b0;
        end else begin
            state    <= state_next;
            owner    <= owner_next;
            i_resp_o <= busy && xfer_done_i && (owner == OWNER_I);
            d_resp_o <= busy && xfer_done_i && (owner == OWNER_D);
        end
    end

    // line data for the owner in its resp cycle
    always_ff @(posedge clk) begin
        if (busy && xfer_done_i) begin
            if (owner == OWNER_I) begin
                i_rdata_o <= xfer_rdata_i;
            end else begin
                d_rdata_o <= xfer_rdata_i;
            end
        end
    end

endmodule : line_arbiter

//--- hw/burst_adapter.sv
`timescale 1ns/1ps

module burst_adapter
import mem_bus_pkg::*, arb_pkg::*;
(
    input   logic       clk,
    input   logic       rst,

    // line transfer from the arbiter held until done
    input   addr_t      xfer_addr_i,
    input   logic       xfer_read_i,
    input   logic       xfer_write_i,
    input   line_t      xfer_wdata_i,
    output  line_t      xfer_rdata_o,
    output  logic       xfer_done_o,

    // burst memory
    output  addr_t      bmem_addr_o,
    output  logic       bmem_read_o,
    output  logic       bmem_write_o,
    output  beat_t      bmem_wdata_o,
    input   logic       bmem_ready_i,
    input   beat_t      bmem_rdata_i,
    input   logic       bmem_rvalid_i
);

    burst_state_t   state, state_next;
    beat_cnt_t      beat_cnt;
    logic           last_beat;
    logic           beat_move;      // a beat moves this cycle
    line_t          rd_line;

    assign last_beat = (beat_cnt == beat_cnt_t'(BURST_LEN - 1));

    always_comb begin
        state_next   = state;
        bmem_read_o  = 1'b0;
        bmem_write_o = 1'b0;
        xfer_done_o  = 1'b0;
        beat_move    = 1'b0;
        case (state)
            BURST_IDLE: begin
                if (xfer_read_i) begin
                    // command goes out only on a ready cycle
                    bmem_read_o = bmem_ready_i;
                    if (bmem_ready_i) begin
                        state_next = BURST_READ_WAIT;
                    end
                end else if (xfer_write_i) begin
                    state_next = BURST_WRITE_BEATS;
                end
            end
            BURST_READ_WAIT: begin
                beat_move = bmem_rvalid_i;      // gaps allowed between beats
                if (bmem_rvalid_i && last_beat) begin
                    state_next = BURST_DONE;
                end
            end
            BURST_WRITE_BEATS: begin
                bmem_write_o = 1'b1;
                beat_move    = bmem_ready_i;    // stalls hold the current beat
                if (bmem_ready_i && last_beat) begin
                    state_next = BURST_DONE;
                end
            end
            BURST_DONE: begin
                xfer_done_o = 1'b1;             // single pulse per transfer
                state_next  = BURST_IDLE;
            end
            default: begin
                state_next = BURST_IDLE;
            end
        endcase
    end

    // address is already line aligned by the arbiter
    assign bmem_addr_o  = xfer_addr_i;
    assign bmem_wdata_o = xfer_wdata_i[beat_cnt * $bits(beat_t) +: $bits(beat_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= BURST_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == BURST_IDLE) begin
                beat_cnt <= '0;
            end else if (beat_move) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // lowest beat arrives first and shifts down to the low bits
    always_ff @(posedge clk) begin
        if ((state == BURST_READ_WAIT) && bmem_rvalid_i) begin
            rd_line <= {bmem_rdata_i, rd_line[$bits(line_t)-1:$bits(beat_t)]};
        end
    end

    assign xfer_rdata_o = rd_line;

endmodule : burst_adapter

//--- hw/line_mem_top.sv
`timescale 1ns/1ps

module line_mem_top
import mem_bus_pkg::*;
#(
    parameter logic D_FIRST = 1'b1      // tie priority for the arbiter
)
(
    input   logic       clk,
    input   logic       rst,

    // instruction port
    input   addr_t      i_addr_i,
    input   logic       i_read_i,
    output  line_t      i_rdata_o,
    output  logic       i_resp_o,

    // data port
    input   addr_t      d_addr_i,
    input   logic       d_read_i,
    input   logic       d_write_i,
    input   line_t      d_wdata_i,
    output  line_t      d_rdata_o,
    output  logic       d_resp_o,

    // burst memory
    output  addr_t      bmem_addr_o,
    output  logic       bmem_read_o,
    output  logic       bmem_write_o,
    output  beat_t      bmem_wdata_o,
    input   logic       bmem_ready_i,
    input   beat_t      bmem_rdata_i,
    input   logic       bmem_rvalid_i
);

    addr_t  xfer_addr;
    logic   xfer_read;
    logic   xfer_write;
    line_t  xfer_wdata;
    line_t  xfer_rdata;
    logic   xfer_done;

    line_arbiter #(
        .D_FIRST        (D_FIRST)
    ) i_line_arbiter (
        .clk            (clk),
        .rst            (rst),
        .i_addr_i       (i_addr_i),
        .i_read_i       (i_read_i),
        .i_rdata_o      (i_rdata_o),
        .i_resp_o       (i_resp_o),
        .d_addr_i       (d_addr_i),
        .d_read_i       (d_read_i),
        .d_write_i      (d_write_i),
        .d_wdata_i      (d_wdata_i),
        .d_rdata_o      (d_rdata_o),
        .d_resp_o       (d_resp_o),
        .xfer_addr_o    (xfer_addr),
        .xfer_read_o    (xfer_read),
        .xfer_write_o   (xfer_write),
        .xfer_wdata_o   (xfer_wdata),
        .xfer_rdata_i   (xfer_rdata),
        .xfer_done_i    (xfer_done)
    );

    burst_adapter i_burst_adapter (
        .clk            (clk),
        .rst            (rst),
        .xfer_addr_i    (xfer_addr),
        .xfer_read_i    (xfer_read),
        .xfer_write_i   (xfer_write),
        .xfer_wdata_i   (xfer_wdata),
        .xfer_rdata_o   (xfer_rdata),
        .xfer_done_o    (xfer_done),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i)
    );

endmodule : line_mem_top

//--- tests/bmem_model.sv
`timescale 1ns/1ps

module bmem_model
import mem_bus_pkg::*;
#(
    parameter addr_t BASE_ADDR = 32'h1eceb000,
    parameter int    LINES     = 16
)
(
    input   logic   clk,
    input   logic   rst,
    input   addr_t  addr_i,
    input   logic   read_i,
    input   logic   write_i,
    input   beat_t  wdata_i,
    input   logic   long_stall_i,       // longer and more frequent ready drops
    output  logic   ready_o,
    output  beat_t  rdata_o,
    output  logic   rvalid_o,
    output  int     fault_cnt_o
);

    beat_t  mem [LINES*BURST_LEN];      // shadow array with one entry per beat
    integer seed;
    integer r;
    int     faults;
    int     stall_left;
    int     rd_base;
    int     rd_idx;
    int     wr_base;
    int     wr_cnt;
    logic   rd_busy;
    addr_t  a;

    assign fault_cnt_o = faults;

    function automatic logic addr_ok(input addr_t addr);
        return (addr >= BASE_ADDR) && (addr < BASE_ADDR + LINES * 32) && (addr[4:0] == 5'd0);
    endfunction

    initial begin
        seed   = 32'heab7c999;
        faults = 0;
        for (int i = 0; i < LINES * BURST_LEN; i++) begin
            a      = BASE_ADDR + i * 8;
            mem[i] = {a, ~a};           // own address up and inverted address down
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ready_o    <= 1'b0;
            rvalid_o   <= 1'b0;
            rdata_o    <= '0;
            stall_left = 0;
            rd_busy    = 1'b0;
            rd_idx     = 0;
            wr_cnt     = 0;
        end else begin
            rvalid_o <= 1'b0;
            if (read_i && write_i) begin
                faults++;
                $display("memory model: read and write command together at %0t", $time);
            end
            if (read_i && ready_o) begin
                if (rd_busy || wr_cnt != 0) begin
                    faults++;
                    $display("memory model: read command before the last one ended at %0t", $time);
                end else if (!addr_ok(addr_i)) begin
                    faults++;
                    $display("memory model: read from bad address %h at %0t", addr_i, $time);
                end else begin
                    rd_busy = 1'b1;
                    rd_idx  = 0;
                    rd_base = (addr_i - BASE_ADDR) >> 3;
                end
            end else if (rd_busy) begin
                r = $random(seed);
                if (r[1:0] != 2'b00) begin      // otherwise a gap this cycle
                    rvalid_o <= 1'b1;
                    rdata_o  <= mem[rd_base + rd_idx];
                    rd_idx++;
                    if (rd_idx == BURST_LEN) begin
                        rd_busy = 1'b0;
                    end
                end
            end
            if (write_i && ready_o) begin
                if (rd_busy) begin
                    faults++;
                    $display("memory model: write command during a read burst at %0t", $time);
                end else if (wr_cnt == 0 && !addr_ok(addr_i)) begin
                    faults++;
                    $display("memory model: write to bad address %h at %0t", addr_i, $time);
                end else begin
                    if (wr_cnt == 0) begin
                        wr_base = (addr_i - BASE_ADDR) >> 3;
                    end
                    mem[wr_base + wr_cnt] = wdata_i;
                    wr_cnt = (wr_cnt + 1) % BURST_LEN;
                end
            end
            r = $random(seed);
            if (stall_left > 0) begin
                stall_left--;
                ready_o <= 1'b0;
            end else if (r[3:0] < (long_stall_i ? 4'd4 : 4'd1)) begin
                stall_left = long_stall_i ? 2 + r[7:4] : r[4];
                ready_o    <= 1'b0;
            end else begin
                ready_o <= 1'b1;
            end
        end
    end

endmodule : bmem_model

//--- tests/line_mem_tb.sv
`timescale 1ns/1ps

module line_mem_tb
import mem_bus_pkg::*;
();

    localparam logic  D_FIRST    = 1'b1;
    localparam addr_t BASE_ADDR  = 32'h1eceb000;
    localparam int    LINES      = 16;
    localparam int    WAIT_LIMIT = 4000;    // cycles per resp wait

    logic   clk;
    logic   rst;
    addr_t  i_addr;
    logic   i_read;
    line_t  i_rdata;
    logic   i_resp;
    addr_t  d_addr;
    logic   d_read;
    logic   d_write;
    line_t  d_wdata;
    line_t  d_rdata;
    logic   d_resp;
    addr_t  bmem_addr;
    logic   bmem_read;
    logic   bmem_write;
    beat_t  bmem_wdata;
    logic   bmem_ready;
    beat_t  bmem_rdata;
    logic   bmem_rvalid;
    logic   long_stall;
    int     model_faults;

    integer seed;
    line_t  ref_mem [LINES];                // testbench copy of memory
    logic   i_pend;
    logic   d_pend;
    logic   d_chk;                          // data resp carries read data
    line_t  i_exp;
    line_t  d_exp;
    int     data_errs;
    int     proto_errs;
    int     order_errs;
    int     timeouts;
    time    i_done_t;
    time    d_done_t;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    line_mem_top #(
        .D_FIRST        (D_FIRST)
    ) i_line_mem_top (
        .clk            (clk),
        .rst            (rst),
        .i_addr_i       (i_addr),
        .i_read_i       (i_read),
        .i_rdata_o      (i_rdata),
        .i_resp_o       (i_resp),
        .d_addr_i       (d_addr),
        .d_read_i       (d_read),
        .d_write_i      (d_write),
        .d_wdata_i      (d_wdata),
        .d_rdata_o      (d_rdata),
        .d_resp_o       (d_resp),
        .bmem_addr_o    (bmem_addr),
        .bmem_read_o    (bmem_read),
        .bmem_write_o   (bmem_write),
        .bmem_wdata_o   (bmem_wdata),
        .bmem_ready_i   (bmem_ready),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_rvalid_i  (bmem_rvalid)
    );

    bmem_model #(
        .BASE_ADDR      (BASE_ADDR),
        .LINES          (LINES)
    ) i_bmem_model (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (bmem_addr),
        .read_i         (bmem_read),
        .write_i        (bmem_write),
        .wdata_i        (bmem_wdata),
        .long_stall_i   (long_stall),
        .ready_o        (bmem_ready),
        .rdata_o        (bmem_rdata),
        .rvalid_o       (bmem_rvalid),
        .fault_cnt_o    (model_faults)
    );

    function automatic line_t expected_line(input addr_t addr);
        return ref_mem[(addr - BASE_ADDR) >> LINE_OFFSET_BITS];
    endfunction

    function automatic addr_t line_addr(input int line);
        return BASE_ADDR + line * 32 + ($random(seed) & 31);   // offset bits are ignored
    endfunction

    function automatic int rand_line();
        return ($random(seed) & 32'h7fff_ffff) % LINES;
    endfunction

    function automatic line_t rand_data();
        line_t v;
        for (int k = 0; k < 8; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    task automatic finish_run();
        int total;
        total = data_errs + proto_errs + order_errs + timeouts + model_faults;
        $display("errors: %0d data, %0d protocol, %0d order, %0d timeout, %0d memory model",
                 data_errs, proto_errs, order_errs, timeouts, model_faults);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic i_fetch(input int line);
        addr_t a;
        int    waited;
        if (timeouts == 0) begin
            a = line_addr(line);
            @(posedge clk);
            i_addr <= a;
            i_read <= 1'b1;
            i_exp  <= expected_line(a);
            i_pend <= 1'b1;
            waited = 0;
            @(posedge clk);
            while (!i_resp && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (!i_resp) begin
                timeouts++;
                $display("timeout: instruction read of line %0d got no resp", line);
            end else begin
                i_read   <= 1'b0;          // dropped on the edge that saw resp
                i_pend   <= 1'b0;
                i_done_t = $time;
            end
        end
    endtask

    task automatic d_access(input int line, input logic wr, input line_t data);
        addr_t a;
        int    waited;
        if (timeouts == 0) begin
            a = line_addr(line);
            @(posedge clk);
            d_addr  <= a;
            d_read  <= !wr;
            d_write <= wr;
            d_wdata <= data;
            d_chk   <= !wr;
            d_pend  <= 1'b1;
            d_exp   <= expected_line(a);
            if (wr) begin
                ref_mem[line] = data;
            end
            waited = 0;
            @(posedge clk);
            while (!d_resp && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (!d_resp) begin
                timeouts++;
                $display("timeout: data access of line %0d got no resp", line);
            end else begin
                d_read   <= 1'b0;
                d_write  <= 1'b0;
                d_pend   <= 1'b0;
                d_done_t = $time;
            end
        end
    endtask

    // compare on every resp
    always @(posedge clk) begin
        if (!rst) begin
            if (i_resp && !i_pend) begin
                proto_errs++;
                $display("instruction resp at %0t with no request pending", $time);
            end else if (i_resp && i_rdata !== i_exp) begin
                data_errs++;
                $display("ERR %0t: instruction read of %h returned %h, expected %h",
                         $time, i_addr, i_rdata, i_exp);
            end
            if (d_resp && !d_pend) begin
                proto_errs++;
                $display("data resp at %0t with no request pending", $time);
            end else if (d_resp && d_chk && d_rdata !== d_exp) begin
                data_errs++;
                $display("ERR %0t: data read of %h returned %h, expected %h",
                         $time, d_addr, d_rdata, d_exp);
            end
            if (bmem_read && !bmem_ready) begin
                proto_errs++;
                $display("read command issued while memory was stalled at %0t", $time);
            end
        end
    end

    initial begin
        int    kind;
        int    la;
        int    lb;
        logic  wr;
        line_t data;
        addr_t ba;
        seed       = 32'heab7c999;
        data_errs  = 0;
        proto_errs = 0;
        order_errs = 0;
        timeouts   = 0;
        i_pend     = 1'b0;
        d_pend     = 1'b0;
        d_chk      = 1'b0;
        rst        <= 1'b1;
        i_addr     <= '0;
        i_read     <= 1'b0;
        d_addr     <= '0;
        d_read     <= 1'b0;
        d_write    <= 1'b0;
        d_wdata    <= '0;
        long_stall <= 1'b0;
        for (int l = 0; l < LINES; l++) begin
            for (int b = 0; b < BURST_LEN; b++) begin
                ba = BASE_ADDR + l * 32 + b * 8;
                ref_mem[l][b*64 +: 64] = {ba, ~ba};
            end
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        i_fetch(rand_line());                       // initial content
        la   = rand_line();
        data = rand_data();
        d_access(la, 1'b1, data);                   // write and read back on both ports
        d_access(la, 1'b0, '0);
        i_fetch(la);

        la = rand_line();
        lb = rand_line();
        fork
            i_fetch(la);
            d_access(lb, 1'b0, '0);
        join
        if ((d_done_t < i_done_t) != D_FIRST) begin
            order_errs++;
            $display("ERR %0t: tie was granted to the wrong port first", $time);
        end

        long_stall <= 1'b1;
        for (int n = 0; n < 6; n++) begin
            la = rand_line();
            d_access(la, 1'b1, rand_data());
            d_access(la, 1'b0, '0);
            i_fetch(la);
        end
        long_stall <= 1'b0;

        for (int n = 0; n < 50; n++) begin
            kind = $random(seed) & 3;
            la   = rand_line();
            lb   = rand_line();
            case (kind)
                0: i_fetch(la);
                1: d_access(la, 1'b0, '0);
                2: d_access(la, 1'b1, rand_data());
                default: begin
                    wr = $random(seed) & 1;
                    if (wr && lb == la) begin
                        lb = (la + 1) % LINES;      // keep the expected order fixed
                    end
                    data = rand_data();
                    fork
                        i_fetch(lb);
                        d_access(la, wr, data);
                    join
                end
            endcase
        end
        finish_run();
    end

endmodule : line_mem_tb

//--- flist.f
hw/mem_bus_pkg.sv
hw/arb_pkg.sv
hw/line_arbiter.sv
hw/burst_adapter.sv
hw/line_mem_top.sv
tests/bmem_model.sv
tests/line_mem_tb.sv
